// ==== Makefile ====
TOP := tb_rv_exec

.PHONY: all lint clean

# build, run, and fail unless the pass message shows up
all: obj_dir/V$(TOP)
	@out="$$(obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

obj_dir/V$(TOP): rv_exec.f $(wildcard hdl/*.sv bench/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f rv_exec.f

lint:
	verilator --lint-only --timescale 1ns/1ps --top-module rv_exec_top \
		hdl/rv_exec_pkg.sv hdl/rv_decode.sv hdl/rv_alu.sv \
		hdl/rv_branch_unit.sv hdl/rv_writeback.sv hdl/rv_exec_top.sv
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f rv_exec.f

clean:
	rm -rf obj_dir

// ==== bench/tb_rv_exec.sv ====
// self-checking testbench for the RV32I execute stage, plays an instruction table through the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

    typedef struct packed {
        rv_exec_pkg::exec_req_t    req;
        rv_exec_pkg::exec_result_t exp;
    } vector_t;

    logic                      clk;
    logic                      rst_n_i;
    logic                      req_valid_i;
    rv_exec_pkg::exec_req_t    req_i;
    logic                      res_valid_o;
    rv_exec_pkg::exec_result_t res_o;

    vector_t vectors [$];
    string   names [$];
    int      accept_at [$];    // edge count just before each entry is taken
    bit      gap_before [int]; // one idle cycle ahead of these entries
    bit      table_ready = 1'b0;
    int      cycle = 0;
    int      chk_idx = 0;
    int      pass_cnt = 0;
    int      fail_cnt = 0;
    int      other_errors = 0;
    bit      cur_ok;

    rv_exec_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic add_vector(input string name, input rv_exec_pkg::inst_t inst,
                              input rv_exec_pkg::word_t pc, input rv_exec_pkg::word_t rs1,
                              input rv_exec_pkg::word_t rs2, input int wb_en, input int rd,
                              input rv_exec_pkg::word_t wb_data, input int jump_en,
                              input rv_exec_pkg::word_t jump_addr, input int illegal);
        vector_t v;
        v.req = {inst, pc, rs1, rs2};
        v.exp = {wb_en[0], rd[4:0], wb_data, jump_en[0], jump_addr, illegal[0]};
        vectors.push_back(v);
        names.push_back(name);
    endtask

    task automatic report_mismatch(input string field, input rv_exec_pkg::word_t exp_val,
                                   input rv_exec_pkg::word_t act_val);
        $display("[ERROR] test %0d (%s) %s: expected %h, got %h",
                 chk_idx, names[chk_idx], field, exp_val, act_val);
        cur_ok = 1'b0;
    endtask

    initial begin : stimulus
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;

        // register-register, rd x3
        add_vector("add",   32'h002081B3, 32'h100, 32'h5, 32'h7, 1, 3, 32'hC, 0, 0, 0);
        add_vector("sub",   32'h402081B3, 32'h100, 32'h5, 32'h7, 1, 3, 32'hFFFFFFFE, 0, 0, 0);
        add_vector("sll31", 32'h002091B3, 32'h100, 32'h3, 32'h3F, 1, 3, 32'h80000000, 0, 0, 0);
        add_vector("slt",   32'h0020A1B3, 32'h100, 32'hFFFFFFFF, 32'h1, 1, 3, 32'h1, 0, 0, 0);
        add_vector("sltu",  32'h0020B1B3, 32'h100, 32'hFFFFFFFF, 32'h1, 1, 3, 32'h0, 0, 0, 0);
        add_vector("xor",   32'h0020C1B3, 32'h100, 32'hF0F0F0F0, 32'h0FF00FF0, 1, 3,
                   32'hFF00FF00, 0, 0, 0);
        add_vector("srl",   32'h0020D1B3, 32'h100, 32'h80000000, 32'h4, 1, 3, 32'h08000000, 0, 0, 0);
        add_vector("sra",   32'h4020D1B3, 32'h100, 32'h80000000, 32'h4, 1, 3, 32'hF8000000, 0, 0, 0);
        add_vector("or",    32'h0020E1B3, 32'h100, 32'hF0000000, 32'hF, 1, 3, 32'hF000000F, 0, 0, 0);
        add_vector("and",   32'h0020F1B3, 32'h100, 32'hFF00FF00, 32'h0FF00FF0, 1, 3,
                   32'h0F000F00, 0, 0, 0);
        gap_before[vectors.size()] = 1'b1;
        // register-immediate, rd x5
        add_vector("addi-", 32'hFFB08293, 32'h200, 32'hA, 32'h0, 1, 5, 32'h5, 0, 0, 0);
        add_vector("addi+", 32'h7FF08293, 32'h200, 32'h1, 32'h0, 1, 5, 32'h800, 0, 0, 0);
        add_vector("xori",  32'hFFF0C293, 32'h200, 32'h12345678, 32'h0, 1, 5, 32'hEDCBA987, 0, 0, 0);
        add_vector("sltiu", 32'hFFF0B293, 32'h200, 32'h7FFFFFFF, 32'h0, 1, 5, 32'h1, 0, 0, 0);
        add_vector("sltiu", 32'hFFF0B293, 32'h200, 32'hFFFFFFFF, 32'h0, 1, 5, 32'h0, 0, 0, 0);
        add_vector("slti",  32'hFFF0A293, 32'h200, 32'h80000000, 32'h0, 1, 5, 32'h1, 0, 0, 0);
        add_vector("srai",  32'h4040D293, 32'h200, 32'h80000010, 32'h0, 1, 5, 32'hF8000001, 0, 0, 0);
        add_vector("srli",  32'h0040D293, 32'h200, 32'h80000010, 32'h0, 1, 5, 32'h08000001, 0, 0, 0);
        add_vector("andi",  32'h0FF0F293, 32'h200, 32'h12345678, 32'h0, 1, 5, 32'h78, 0, 0, 0);
        gap_before[vectors.size()] = 1'b1;
        // branches at pc 0x1000, forward +16 and backward -8
        add_vector("beq t",  32'h00208863, 32'h1000, 32'h55, 32'h55, 0, 0, 0, 1, 32'h1010, 0);
        add_vector("beq n",  32'h00208863, 32'h1000, 32'h55, 32'h56, 0, 0, 0, 0, 0, 0);
        add_vector("bne t",  32'hFE209CE3, 32'h1000, 32'h1, 32'h2, 0, 0, 0, 1, 32'hFF8, 0);
        add_vector("bne n",  32'hFE209CE3, 32'h1000, 32'h2, 32'h2, 0, 0, 0, 0, 0, 0);
        add_vector("blt t",  32'h0020C863, 32'h1000, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 1, 32'h1010, 0);
        add_vector("blt n",  32'h0020C863, 32'h1000, 32'h1, 32'hFFFFFFFF, 0, 0, 0, 0, 0, 0);
        add_vector("bge t",  32'hFE20DCE3, 32'h1000, 32'h1, 32'hFFFFFFFF, 0, 0, 0, 1, 32'hFF8, 0);
        add_vector("bge n",  32'hFE20DCE3, 32'h1000, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 0, 0, 0);
        add_vector("bltu t", 32'h0020E863, 32'h1000, 32'h1, 32'hFFFFFFFF, 0, 0, 0, 1, 32'h1010, 0);
        add_vector("bltu n", 32'h0020E863, 32'h1000, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 0, 0, 0);
        add_vector("bgeu t", 32'hFE20FCE3, 32'h1000, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 1, 32'hFF8, 0);
        add_vector("bgeu n", 32'hFE20FCE3, 32'h1000, 32'h1, 32'hFFFFFFFF, 0, 0, 0, 0, 0, 0);
        gap_before[vectors.size()] = 1'b1;
        // jumps and upper immediates
        add_vector("jal",   32'h100000EF, 32'h2000, 32'h0, 32'h0, 1, 1, 32'h2004, 1, 32'h2100, 0);
        add_vector("jalr",  32'h003080E7, 32'h2040, 32'h3000, 32'h0, 1, 1, 32'h2044, 1, 32'h3002, 0);
        add_vector("lui",   32'h123453B7, 32'h2080, 32'hFFFFFFFF, 32'h0, 1, 7, 32'h12345000, 0, 0, 0);
        add_vector("auipc", 32'hFFFFF397, 32'h3000, 32'h0, 32'h0, 1, 7, 32'h2000, 0, 0, 0);
        gap_before[vectors.size()] = 1'b1;
        // opcodes outside the kept set
        add_vector("load",  32'h0000A283, 32'h4000, 32'h10, 32'h0, 0, 0, 0, 0, 0, 1);
        add_vector("store", 32'h0020A023, 32'h4004, 32'h10, 32'h20, 0, 0, 0, 0, 0, 1);
        add_vector("fence", 32'h0FF0000F, 32'h4008, 32'h0, 32'h0, 0, 0, 0, 0, 0, 1);
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        repeat (3) begin // quiet outputs after reset
            @(posedge clk);
            #2;
        end
        for (int i = 0; i < vectors.size(); i++) begin
            if (gap_before.exists(i)) begin
                req_valid_i = 1'b0;
                @(posedge clk);
                #2;
            end
            req_valid_i = 1'b1;
            req_i       = vectors[i].req;
            accept_at.push_back(cycle); // driven now, taken at the next edge
            @(posedge clk);
            #2;
        end
        req_valid_i = 1'b0;
        repeat (4) @(posedge clk); // latency is fixed at two cycles

        if (chk_idx < vectors.size()) begin
            $display("only %0d of %0d results came back", chk_idx, vectors.size());
            other_errors++;
        end
        $display("tests passed %0d, failed %0d, other errors %0d",
                 pass_cnt, fail_cnt, other_errors);
        if (fail_cnt == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // outputs are sampled on the falling edge, well away from the register updates
    initial begin : result_check
        rv_exec_pkg::exec_result_t e;
        wait (rst_n_i);
        forever begin
            @(negedge clk);
            if (!res_valid_o) begin
                if (res_o.wb_en || res_o.jump_en) begin
                    $display("wb_en or jump_en high without a valid result at cycle %0d", cycle);
                    other_errors++;
                end
            end else if (chk_idx >= vectors.size()) begin
                $display("result at cycle %0d with no request outstanding", cycle);
                other_errors++;
            end else begin
                e      = vectors[chk_idx].exp;
                cur_ok = 1'b1;
                if (cycle != accept_at[chk_idx] + 2) begin
                    $display("test %0d returned %0d cycles after it was taken",
                             chk_idx, cycle - accept_at[chk_idx]);
                    cur_ok = 1'b0;
                end
                if (res_o.wb_en !== e.wb_en) report_mismatch("wb_en", 32'(e.wb_en), 32'(res_o.wb_en));
                if (e.wb_en && res_o.rd !== e.rd) report_mismatch("rd", 32'(e.rd), 32'(res_o.rd));
                if (e.wb_en && res_o.wb_data !== e.wb_data) report_mismatch("wb_data", e.wb_data,
                                                                            res_o.wb_data);
                if (res_o.jump_en !== e.jump_en) report_mismatch("jump_en", 32'(e.jump_en),
                                                                 32'(res_o.jump_en));
                if (e.jump_en && res_o.jump_addr !== e.jump_addr) report_mismatch("jump_addr",
                                                                  e.jump_addr, res_o.jump_addr);
                if (res_o.illegal !== e.illegal) report_mismatch("illegal", 32'(e.illegal),
                                                                 32'(res_o.illegal));
                $display("test %0d %s: %s", chk_idx, names[chk_idx], cur_ok ? "pass" : "fail");
                if (cur_ok) pass_cnt++;
                else fail_cnt++;
                chk_idx++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = (16 + vectors.size() + gap_before.size() + 10) * 40;
        #limit;
        $display("watchdog expired after %0d ns before the run completed", limit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
// combinational integer unit of the execute stage, one result per decoded operation
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire rv_exec_pkg::dec_op_t op_i,
    output rv_exec_pkg::word_t        result_o
);

    rv_exec_pkg::word_t  a;
    rv_exec_pkg::word_t  b;
    rv_exec_pkg::shamt_t shamt;

    rv_exec_pkg::word_t sum;
    rv_exec_pkg::word_t diff;
    rv_exec_pkg::word_t shl;
    rv_exec_pkg::word_t shr_logic;
    rv_exec_pkg::word_t shr_arith;
    logic               lt_signed;
    logic               lt_unsigned;

    assign a     = op_i.opnd_a;
    assign b     = op_i.opnd_b;
    assign shamt = op_i.opnd_b[4:0]; // upper bits of b ignored for shifts

    // adder and subtractor
    assign sum  = a + b;
    assign diff = a - b;

    // compares
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // shifter
    assign shl       = a << shamt;
    assign shr_logic = a >> shamt;
    assign shr_arith = rv_exec_pkg::word_t'($signed(a) >>> shamt); // sign fill

    always_comb begin
        unique case (op_i.alu_op)
            rv_exec_pkg::ALU_ADD: begin
                result_o = sum;
            end
            rv_exec_pkg::ALU_SUB: begin
                result_o = diff; // wraps mod 2^32
            end
            rv_exec_pkg::ALU_SLL: begin
                result_o = shl;
            end
            rv_exec_pkg::ALU_SLT: begin
                result_o = {{(rv_exec_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_exec_pkg::ALU_SLTU: begin
                result_o = {{(rv_exec_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_exec_pkg::ALU_XOR: begin
                result_o = a ^ b;
            end
            rv_exec_pkg::ALU_SRL: begin
                result_o = shr_logic;
            end
            rv_exec_pkg::ALU_SRA: begin
                result_o = shr_arith;
            end
            rv_exec_pkg::ALU_OR: begin
                result_o = a | b;
            end
            rv_exec_pkg::ALU_AND: begin
                result_o = a & b;
            end
            default: begin
                result_o = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_branch_unit.sv ====
// branch and jump resolution next to the ALU, yields redirect target and link value
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit (
    input  wire rv_exec_pkg::dec_op_t op_i,
    output rv_exec_pkg::br_res_t      res_o
);

    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               taken;
    logic               is_jump;
    rv_exec_pkg::word_t pc_target;
    rv_exec_pkg::word_t reg_target;

    assign eq   = op_i.rs1_data == op_i.rs2_data;
    assign lt_s = $signed(op_i.rs1_data) < $signed(op_i.rs2_data);
    assign lt_u = op_i.rs1_data < op_i.rs2_data;

    assign pc_target  = op_i.pc + op_i.imm;
    assign reg_target = op_i.rs1_data + op_i.imm;

    always_comb begin
        taken   = 1'b0;
        is_jump = 1'b0;
        unique case (op_i.br_kind)
            rv_exec_pkg::BR_BEQ:  taken = eq;
            rv_exec_pkg::BR_BNE:  taken = !eq;
            rv_exec_pkg::BR_BLT:  taken = lt_s;
            rv_exec_pkg::BR_BGE:  taken = !lt_s;
            rv_exec_pkg::BR_BLTU: taken = lt_u;
            rv_exec_pkg::BR_BGEU: taken = !lt_u;
            rv_exec_pkg::BR_JAL, rv_exec_pkg::BR_JALR: begin
                taken   = 1'b1;
                is_jump = 1'b1;
            end
            default: begin
                taken   = 1'b0;
                is_jump = 1'b0;
            end
        endcase
    end

    always_comb begin
        res_o.jump_en = taken;
        if (op_i.br_kind == rv_exec_pkg::BR_JALR) begin
            res_o.jump_addr = {reg_target[rv_exec_pkg::XLEN-1:1], 1'b0}; // lsb dropped
        end else begin
            res_o.jump_addr = pc_target;
        end
        res_o.link_en   = is_jump;
        res_o.link_data = op_i.pc + rv_exec_pkg::word_t'(rv_exec_pkg::INST_BYTES);
    end

endmodule

`default_nettype wire

// ==== hdl/rv_decode.sv ====
// first pipeline register of the execute stage, turns a raw request into a decoded operation
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire                            req_valid_i,
    input  wire rv_exec_pkg::exec_req_t    req_i,
    output logic                           op_valid_o,
    output rv_exec_pkg::dec_op_t           op_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               alt_bit;
    rv_exec_pkg::word_t imm_i, imm_b, imm_j, imm_u;
    rv_exec_pkg::alu_op_e alu_op;
    rv_exec_pkg::dec_op_t op_d;

    assign opcode  = req_i.inst[6:0];
    assign funct3  = req_i.inst[14:12];
    assign alt_bit = req_i.inst[rv_exec_pkg::FUNCT7_ALT_BIT];

    assign imm_i = {{20{req_i.inst[31]}}, req_i.inst[31:20]};
    assign imm_b = {{19{req_i.inst[31]}}, req_i.inst[31], req_i.inst[7],
                    req_i.inst[30:25], req_i.inst[11:8], 1'b0};
    assign imm_j = {{11{req_i.inst[31]}}, req_i.inst[31], req_i.inst[19:12],
                    req_i.inst[20], req_i.inst[30:21], 1'b0};
    assign imm_u = {req_i.inst[31:12], 12'b0};

    // funct3 to alu op, shared by OP and OP_IMM
    always_comb begin
        unique case (funct3)
            rv_exec_pkg::F3_ADD_SUB: begin
                // no subi in rv32i, bit 30 is immediate there
                alu_op = (opcode == rv_exec_pkg::OPC_OP && alt_bit) ?
                         rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
            end
            rv_exec_pkg::F3_SLL:  alu_op = rv_exec_pkg::ALU_SLL;
            rv_exec_pkg::F3_SLT:  alu_op = rv_exec_pkg::ALU_SLT;
            rv_exec_pkg::F3_SLTU: alu_op = rv_exec_pkg::ALU_SLTU;
            rv_exec_pkg::F3_XOR:  alu_op = rv_exec_pkg::ALU_XOR;
            rv_exec_pkg::F3_SR:   alu_op = alt_bit ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
            rv_exec_pkg::F3_OR:   alu_op = rv_exec_pkg::ALU_OR;
            default:              alu_op = rv_exec_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        op_d          = '0;
        op_d.alu_op   = rv_exec_pkg::ALU_ADD;
        op_d.opnd_a   = req_i.rs1_data;
        op_d.opnd_b   = req_i.rs2_data;
        op_d.br_kind  = rv_exec_pkg::BR_NONE;
        op_d.rs1_data = req_i.rs1_data;
        op_d.rs2_data = req_i.rs2_data;
        op_d.pc       = req_i.pc;
        op_d.imm      = imm_i;
        op_d.rd       = req_i.inst[11:7];
        op_d.wr_en    = 1'b1;
        op_d.illegal  = 1'b0;

        case (opcode)
            rv_exec_pkg::OPC_OP: op_d.alu_op = alu_op;
            rv_exec_pkg::OPC_OP_IMM: begin
                op_d.alu_op = alu_op;
                op_d.opnd_b = imm_i; // shamt sits in imm[4:0]
            end
            rv_exec_pkg::OPC_LUI: begin
                op_d.opnd_a = '0;
                op_d.opnd_b = imm_u;
            end
            rv_exec_pkg::OPC_AUIPC: begin
                op_d.opnd_a = req_i.pc;
                op_d.opnd_b = imm_u;
            end
            rv_exec_pkg::OPC_JAL: begin
                op_d.br_kind = rv_exec_pkg::BR_JAL;
                op_d.imm     = imm_j;
            end
            rv_exec_pkg::OPC_JALR: begin
                op_d.br_kind = rv_exec_pkg::BR_JALR;
                if (funct3 != rv_exec_pkg::F3_JALR) begin
                    op_d.illegal = 1'b1;
                end
            end
            rv_exec_pkg::OPC_BRANCH: begin
                op_d.imm   = imm_b;
                op_d.wr_en = 1'b0;
                case (funct3)
                    rv_exec_pkg::F3_BEQ:  op_d.br_kind = rv_exec_pkg::BR_BEQ;
                    rv_exec_pkg::F3_BNE:  op_d.br_kind = rv_exec_pkg::BR_BNE;
                    rv_exec_pkg::F3_BLT:  op_d.br_kind = rv_exec_pkg::BR_BLT;
                    rv_exec_pkg::F3_BGE:  op_d.br_kind = rv_exec_pkg::BR_BGE;
                    rv_exec_pkg::F3_BLTU: op_d.br_kind = rv_exec_pkg::BR_BLTU;
                    rv_exec_pkg::F3_BGEU: op_d.br_kind = rv_exec_pkg::BR_BGEU;
                    default:              op_d.illegal = 1'b1;
                endcase
            end
            default: op_d.illegal = 1'b1; // loads, stores, fence, system
        endcase

        // an illegal op must neither write nor redirect
        if (op_d.illegal || !req_valid_i) begin
            op_d.wr_en   = 1'b0;
            op_d.br_kind = rv_exec_pkg::BR_NONE;
        end
        if (!req_valid_i) begin
            op_d.illegal = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        op_o <= op_d;
        if (!rst_n_i) begin
            op_valid_o   <= 1'b0;
            op_o.wr_en   <= 1'b0;
            op_o.illegal <= 1'b0;
            op_o.br_kind <= rv_exec_pkg::BR_NONE;
        end else begin
            op_valid_o <= req_valid_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_exec_pkg.sv ====
// shared widths, RV32I encodings and the structs passed between the execute stage blocks
`default_nettype none

package rv_exec_pkg;

    localparam int unsigned XLEN = 32;
    localparam int unsigned INST_BYTES = 4; // next sequential instruction

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [4:0]      shamt_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam int unsigned FUNCT7_ALT_BIT = 30; // sub / sra select

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_kind_e;

    typedef struct packed {
        inst_t inst;
        word_t pc;
        word_t rs1_data;
        word_t rs2_data;
    } exec_req_t;

    typedef struct packed {
        alu_op_e  alu_op;
        word_t    opnd_a;
        word_t    opnd_b;
        br_kind_e br_kind;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    pc;
        word_t    imm;
        reg_idx_t rd;
        logic     wr_en;
        logic     illegal;
    } dec_op_t;

    typedef struct packed {
        logic  jump_en;
        word_t jump_addr;
        logic  link_en;
        word_t link_data;
    } br_res_t;

    typedef struct packed {
        logic     wb_en;
        reg_idx_t rd;
        word_t    wb_data;
        logic     jump_en;
        word_t    jump_addr;
        logic     illegal;
    } exec_result_t;

endpackage

`default_nettype wire

// ==== hdl/rv_exec_top.sv ====
// RV32I execute stage top, two-cycle pipeline of decode, ALU plus branch, and write-back
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          req_valid_i,
    input  wire rv_exec_pkg::exec_req_t  req_i,
    output logic                         res_valid_o,
    output rv_exec_pkg::exec_result_t    res_o
);

    logic                 op_valid;
    rv_exec_pkg::dec_op_t dec_op;
    rv_exec_pkg::word_t   alu_result;
    rv_exec_pkg::br_res_t br_res;

    rv_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .op_valid_o  (op_valid),
        .op_o        (dec_op)
    );

    // alu and branch unit run side by side on the same op
    rv_alu u_alu (
        .op_i     (dec_op),
        .result_o (alu_result)
    );

    rv_branch_unit u_branch (
        .op_i  (dec_op),
        .res_o (br_res)
    );

    rv_writeback u_writeback (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op_valid_i   (op_valid),
        .op_i         (dec_op),
        .alu_result_i (alu_result),
        .br_res_i     (br_res),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_writeback.sv ====
// output register of the execute stage, merges ALU and branch results into one result
`timescale 1ns/1ps
`default_nettype none

module rv_writeback (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         op_valid_i,
    input  wire rv_exec_pkg::dec_op_t   op_i,
    input  wire rv_exec_pkg::word_t     alu_result_i,
    input  wire rv_exec_pkg::br_res_t   br_res_i,
    output logic                        res_valid_o,
    output rv_exec_pkg::exec_result_t   res_o
);

    rv_exec_pkg::word_t wb_data;

    // jal / jalr write the return address, everything else the alu
    assign wb_data = br_res_i.link_en ? br_res_i.link_data : alu_result_i;

    always_ff @(posedge clk) begin
        res_o.rd        <= op_i.rd;
        res_o.wb_data   <= wb_data;
        res_o.jump_addr <= br_res_i.jump_addr;
        if (!rst_n_i) begin
            res_valid_o   <= 1'b0;
            res_o.wb_en   <= 1'b0;
            res_o.jump_en <= 1'b0;
            res_o.illegal <= 1'b0;
        end else begin
            res_valid_o   <= op_valid_i;
            res_o.wb_en   <= op_valid_i & op_i.wr_en;
            res_o.jump_en <= op_valid_i & br_res_i.jump_en;
            res_o.illegal <= op_valid_i & op_i.illegal;
        end
    end

endmodule

`default_nettype wire

// ==== rv_exec.f ====
hdl/rv_exec_pkg.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_writeback.sv
hdl/rv_exec_top.sv
bench/tb_rv_exec.sv
